//--- snn_spike_readout.f
verilog/snn_pkg.sv
verilog/lif_row_engine.sv
verilog/spike_collector.sv
verilog/spike_rate_counter.sv
verilog/host_readout.sv
verilog/snn_spike_readout.sv
tests/snn_spike_readout_tb.sv

//--- Makefile
# Verilator flow for the SNN spike readout tile

VERILATOR ?= verilator
TOP       ?= snn_spike_readout_tb
FILELIST  ?= snn_spike_readout.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/snn_spike_readout_tb.sv
// Testbench for the SNN spike readout tile
// Behavioural LIF model, random beats, checked host reads and counts
`timescale 1ns/1ns
`default_nettype none

module snn_spike_readout_tb
    import snn_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                collect_enable;
    logic                clear_run;
    syn_beat_t           syn_in;
    logic                host_rd_en;
    rd_src_e             host_rd_src;
    logic [ADDR_W-1:0]   host_rd_addr;
    logic [PE_COUNT-1:0] host_rd_data;
    logic                host_rd_valid;
    logic [CNT_W-1:0]    spike_count;

    // ====================
    // Reference model state
    // ====================
    logic [VMEM_W-1:0]   m_vmem [ROWS][PE_COUNT];
    logic [PE_COUNT-1:0] m_buf  [BUF_DEPTH];
    int                  m_rate [PE_COUNT];
    int                  m_count;

    logic [PE_COUNT-1:0] exp_q   [$];     // Expected read words, in order
    int unsigned         stamp_q [$];     // Request cycle of each read
    int unsigned         cycle       = 0;
    int                  checks      = 0;
    int                  read_checks = 0;
    int                  errors      = 0;
    int                  read_errors = 0;

    snn_spike_readout dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .collect_enable (collect_enable),
        .clear_run      (clear_run),
        .syn_in         (syn_in),
        .host_rd_en     (host_rd_en),
        .host_rd_src    (host_rd_src),
        .host_rd_addr   (host_rd_addr),
        .host_rd_data   (host_rd_data),
        .host_rd_valid  (host_rd_valid),
        .spike_count    (spike_count)
    );

    always #5 clk = ~clk;                 // 10 ns period

    always @(posedge clk) cycle <= cycle + 1;

    // ====================
    // Read result checker
    // ====================
    always @(negedge clk) begin
        if (rst_n && host_rd_valid) begin
            read_checks++;
            assert (exp_q.size() > 0) else begin
                read_errors++;
                $display("Read result at %0t with no request pending", $time);
            end
            if (exp_q.size() > 0) begin
                assert (stamp_q[0] + 2 == cycle) else begin
                    read_errors++;
                    $display("Read result at %0t came %0d cycles after its request",
                             $time, cycle - stamp_q[0]);
                end
                assert (host_rd_data == exp_q[0]) else begin
                    read_errors++;
                    $display("mismatch at %0t: host read got %h, expected %h",
                             $time, host_rd_data, exp_q[0]);
                end
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
        end else if (stamp_q.size() > 0) begin
            // Valid must come exactly 2 cycles after the request
            assert (cycle < stamp_q[0] + 2) else begin
                read_errors++;
                $display("Read result missing at %0t, 2 cycles after its request", $time);
                void'(exp_q.pop_front());
                void'(stamp_q.pop_front());
            end
        end
    end

    // ====================
    // Model tasks
    // ====================
    task automatic model_clear();
        for (int r = 0; r < ROWS; r++) begin
            for (int p = 0; p < PE_COUNT; p++) m_vmem[r][p] = '0;
        end
        for (int a = 0; a < BUF_DEPTH; a++) m_buf[a] = '0;
        for (int p = 0; p < PE_COUNT; p++) m_rate[p] = 0;
        m_count = 0;
    endtask

    // Leak, integrate, fire; store and count only when enabled
    task automatic model_beat(input syn_beat_t b, input logic en);
        int                  v;
        int                  s;
        int                  addr;
        logic [PE_COUNT-1:0] spk;
        spk = '0;
        for (int p = 0; p < PE_COUNT; p++) begin
            v = int'(m_vmem[b.row][p]);
            s = v - (v >> LEAK_SHIFT) + int'(b.current[p]);
            if (s > (1 << VMEM_W) - 1) s = (1 << VMEM_W) - 1;   // Clamp
            if (s >= V_THRESH) begin
                spk[p] = 1'b1;
                m_vmem[b.row][p] = '0;                      // Reset after firing
            end else begin
                m_vmem[b.row][p] = VMEM_W'(s);
            end
        end
        if (en) begin
            addr = int'(b.timestep) * ROWS + int'(b.row);
            m_buf[addr] = spk;
            if (spk != '0 && m_count < (1 << CNT_W) - 1) m_count++;
            for (int p = 0; p < PE_COUNT; p++) begin
                if (spk[p] && m_rate[p] < (1 << RATE_W) - 1) m_rate[p]++;
            end
        end
    endtask

    // ====================
    // Drivers
    // ====================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            syn_in     <= '0;
            host_rd_en <= 1'b0;
            clear_run  <= 1'b0;
        end
    endtask

    task automatic set_enable(input logic en);
        @(posedge clk);
        syn_in         <= '0;
        host_rd_en     <= 1'b0;
        collect_enable <= en;
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        syn_in     <= '0;
        host_rd_en <= 1'b0;
        clear_run  <= 1'b1;
        model_clear();
        idle(2);
    endtask

    // Rows cycle fastest, then timesteps; full drives maximum currents
    task automatic send_beats(input int n, input bit full);
        syn_beat_t b;
        for (int i = 0; i < n; i++) begin
            b.valid    = 1'b1;
            b.row      = ROW_W'(i % ROWS);
            b.timestep = TS_W'((i / ROWS) % MAX_TIMESTEPS);
            for (int p = 0; p < PE_COUNT; p++) begin
                b.current[p] = full ? CUR_W'((1 << CUR_W) - 1) : CUR_W'($urandom % 36);
            end
            @(posedge clk);
            model_beat(b, collect_enable);   // Enable as the consumers will see it
            syn_in     <= b;
            host_rd_en <= 1'b0;
            clear_run  <= 1'b0;
        end
        idle(2);    // Let the last beat reach both consumers
    endtask

    task automatic issue_read(input rd_src_e src, input int addr);
        logic [PE_COUNT-1:0] exp;
        if (src == RD_RATES) exp = PE_COUNT'(m_rate[addr % PE_COUNT]);
        else exp = m_buf[addr];
        @(posedge clk);
        syn_in       <= '0;
        clear_run    <= 1'b0;
        host_rd_en   <= 1'b1;
        host_rd_src  <= src;
        host_rd_addr <= ADDR_W'(addr);
        exp_q.push_back(exp);
        stamp_q.push_back(cycle + 1);   // Cycle count once this edge has passed
    endtask

    task automatic wait_reads();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 20) begin
            idle(1);
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout at %0t with %0d host reads still pending", $time, exp_q.size());
            $display("Checks: %0d, errors: %0d", checks + read_checks,
                     errors + read_errors + 1);
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    // Every buffer word, with rate reads interleaved for the first PEs
    task automatic read_all();
        for (int a = 0; a < BUF_DEPTH; a++) begin
            issue_read(RD_SPIKES, a);
            if (a < PE_COUNT) issue_read(RD_RATES, a + PE_COUNT * int'($urandom % 8));
        end
        wait_reads();
    endtask

    task automatic check_count();
        @(negedge clk);
        checks++;
        assert (int'(spike_count) == m_count) else begin
            errors++;
            $display("mismatch at %0t: spike_count %0d, expected %0d",
                     $time, spike_count, m_count);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        void'($urandom(32'hea15425b));
        clk            = 1'b0;
        rst_n          = 1'b0;
        collect_enable = 1'b0;
        clear_run      = 1'b0;
        syn_in         = '0;
        host_rd_en     = 1'b0;
        host_rd_src    = RD_SPIKES;
        host_rd_addr   = '0;
        model_clear();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!host_rd_valid) else begin
            errors++;
            $display("host_rd_valid is high right after reset at %0t", $time);
        end
        check_count();

        set_enable(1'b1);                  // LIF dynamics over every entry
        send_beats(BUF_DEPTH, 1'b0);
        read_all();
        check_count();

        set_enable(1'b0);                  // Membranes move, nothing stored
        send_beats(BUF_DEPTH, 1'b0);
        read_all();
        check_count();

        set_enable(1'b1);                  // Picks up the advanced membranes
        send_beats(BUF_DEPTH / 2, 1'b0);
        read_all();
        check_count();

        pulse_clear();                     // Everything back to zero
        read_all();
        check_count();
        send_beats(BUF_DEPTH, 1'b0);
        read_all();
        check_count();

        send_beats(300, 1'b1);             // Rates and count saturate
        read_all();
        check_count();

        $display("Checks: %0d, errors: %0d", checks + read_checks, errors + read_errors);
        if (errors + read_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/snn_spike_readout.sv
// SNN spike readout tile: LIF row engine feeding a spike collector and
// a rate counter, both read through one host port
`timescale 1ns/1ns
`default_nettype none

module snn_spike_readout
    import snn_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                collect_enable,  // Level, gates both consumers
    input  logic                clear_run,       // One-cycle clear pulse
    input  syn_beat_t           syn_in,
    input  logic                host_rd_en,
    input  rd_src_e             host_rd_src,
    input  logic [ADDR_W-1:0]   host_rd_addr,    // Low PE_W bits for rates
    output logic [PE_COUNT-1:0] host_rd_data,
    output logic                host_rd_valid,
    output logic [CNT_W-1:0]    spike_count
);

    // ====================
    // Internal nets
    // ====================
    spike_beat_t         spike_beat;     // Fans out to both consumers
    logic                coll_rd_en;
    logic                rate_rd_en;
    logic [PE_COUNT-1:0] coll_rd_data;
    logic [RATE_W-1:0]   rate_rd_data;

    lif_row_engine u_lif (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_run  (clear_run),
        .syn_in     (syn_in),
        .spike_beat (spike_beat)
    );

    spike_collector u_coll (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_run      (clear_run),
        .collect_enable (collect_enable),
        .spike_beat     (spike_beat),
        .rd_en          (coll_rd_en),
        .rd_addr        (host_rd_addr),
        .rd_data        (coll_rd_data),
        .spike_count    (spike_count)
    );

    spike_rate_counter u_rate (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_run      (clear_run),
        .collect_enable (collect_enable),
        .spike_beat     (spike_beat),
        .rd_en          (rate_rd_en),
        .rd_pe          (host_rd_addr[PE_W-1:0]),
        .rd_data        (rate_rd_data)
    );

    host_readout u_host (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_rd_en    (host_rd_en),
        .host_rd_src   (host_rd_src),
        .coll_rd_en    (coll_rd_en),
        .rate_rd_en    (rate_rd_en),
        .coll_rd_data  (coll_rd_data),
        .rate_rd_data  (rate_rd_data),
        .host_rd_data  (host_rd_data),
        .host_rd_valid (host_rd_valid)
    );

endmodule

`default_nettype wire

//--- verilog/host_readout.sv
// Host readout: decodes the read source into one consumer strobe and
// returns the chosen word two cycles after the request
`timescale 1ns/1ns
`default_nettype none

module host_readout
    import snn_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                host_rd_en,     // Request strobe
    input  rd_src_e             host_rd_src,
    output logic                coll_rd_en,     // To spike collector
    output logic                rate_rd_en,     // To rate counter
    input  logic [PE_COUNT-1:0] coll_rd_data,
    input  logic [RATE_W-1:0]   rate_rd_data,
    output logic [PE_COUNT-1:0] host_rd_data,
    output logic                host_rd_valid
);

    // ====================
    // Source decode
    // ====================
    assign coll_rd_en = host_rd_en && (host_rd_src == RD_SPIKES);
    assign rate_rd_en = host_rd_en && (host_rd_src == RD_RATES);

    // Stage 1, consumers fetch while the request is tracked here
    logic    rd_pend;
    rd_src_e src_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= host_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (host_rd_en) begin
            src_q <= host_rd_src;   // Which word to pick next cycle
        end
    end

    // ====================
    // Stage 2, result
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rd_valid <= 1'b0;
        end else begin
            host_rd_valid <= rd_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pend) begin
            host_rd_data <= (src_q == RD_RATES) ? PE_COUNT'(rate_rd_data)
                                                : coll_rd_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/spike_rate_counter.sv
// Spike rate counter: one saturating spike counter per PE, with a
// registered read port
`timescale 1ns/1ns
`default_nettype none

module spike_rate_counter
    import snn_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clear_run,       // Zero all counters
    input  logic              collect_enable,  // Gates counting
    input  spike_beat_t       spike_beat,
    input  logic              rd_en,
    input  logic [PE_W-1:0]   rd_pe,           // PE to read
    output logic [RATE_W-1:0] rd_data
);

    // ====================
    // Counters
    // ====================
    logic [RATE_W-1:0] rate [PE_COUNT];

    logic count_en;

    assign count_en = spike_beat.valid && collect_enable;

    always_ff @(posedge clk) begin
        if (!rst_n || clear_run) begin
            for (int p = 0; p < PE_COUNT; p++) begin
                rate[p] <= '0;
            end
        end else if (count_en) begin
            for (int p = 0; p < PE_COUNT; p++) begin
                // Bump only spiking PEs, stop at 255
                if (spike_beat.spikes[p] && rate[p] != {RATE_W{1'b1}}) begin
                    rate[p] <= rate[p] + 1'b1;
                end
            end
        end
    end

    // ====================
    // Read port
    // ====================
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rate[rd_pe];   // Pre-update value on a same-cycle hit
        end
    end

endmodule

`default_nettype wire

//--- verilog/spike_collector.sv
// Spike collector: stores spike vectors by timestep and row, counts
// beats with at least one spike, and serves registered buffer reads
`timescale 1ns/1ns
`default_nettype none

module spike_collector
    import snn_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear_run,       // Zero buffer and count
    input  logic                collect_enable,  // Gates storing and counting
    input  spike_beat_t         spike_beat,
    input  logic                rd_en,
    input  logic [ADDR_W-1:0]   rd_addr,
    output logic [PE_COUNT-1:0] rd_data,
    output logic [CNT_W-1:0]    spike_count      // Nonzero vectors stored
);

    // ====================
    // Buffer
    // ====================
    logic [PE_COUNT-1:0] spike_buf [BUF_DEPTH];

    logic [ADDR_W-1:0] wr_addr;
    logic              wr_en;
    logic              any_spike;

    // Entry = timestep * ROWS + row
    assign wr_addr   = ADDR_W'(spike_beat.timestep) * ADDR_W'(ROWS)
                     + ADDR_W'(spike_beat.row);
    assign wr_en     = spike_beat.valid && collect_enable;
    assign any_spike = |spike_beat.spikes;

    // Later writes to the same entry overwrite it
    always_ff @(posedge clk) begin
        if (!rst_n || clear_run) begin
            for (int i = 0; i < BUF_DEPTH; i++) begin
                spike_buf[i] <= '0;
            end
        end else if (wr_en) begin
            spike_buf[wr_addr] <= spike_beat.spikes;
        end
    end

    // ====================
    // Nonzero beat count
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n || clear_run) begin
            spike_count <= '0;
        end else if (wr_en && any_spike) begin
            if (spike_count != {CNT_W{1'b1}}) begin   // Hold at max
                spike_count <= spike_count + 1'b1;
            end
        end
    end

    // ====================
    // Read port
    // ====================
    // Same-cycle write is not seen, reads one cycle later are
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= spike_buf[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- verilog/lif_row_engine.sv
// LIF row engine: leaks and integrates one row of membranes per input
// beat and emits the registered spike vector one cycle later
`timescale 1ns/1ns
`default_nettype none

module lif_row_engine
    import snn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear_run,     // Zero all membranes
    input  syn_beat_t   syn_in,
    output spike_beat_t spike_beat
);

    // ====================
    // Membrane state
    // ====================
    logic [VMEM_W-1:0] vmem [ROWS][PE_COUNT];

    // Per-PE datapath for the addressed row
    logic [VMEM_W-1:0] old_v  [PE_COUNT];
    logic [VMEM_W-1:0] leak_v [PE_COUNT];  // After leak
    logic [VMEM_W:0]   sum_v  [PE_COUNT];  // One extra bit for overflow
    logic [VMEM_W-1:0] next_v [PE_COUNT];  // Saturated result
    logic [PE_COUNT-1:0] fire;

    // ====================
    // Leak, integrate, fire
    // ====================
    always_comb begin
        for (int p = 0; p < PE_COUNT; p++) begin
            old_v[p]  = vmem[syn_in.row][p];
            // v - v/8
            leak_v[p] = old_v[p] - (old_v[p] >> LEAK_SHIFT);
            sum_v[p]  = {1'b0, leak_v[p]} + (VMEM_W + 1)'(syn_in.current[p]);
            // Clamp at the top of the range
            next_v[p] = sum_v[p][VMEM_W] ? {VMEM_W{1'b1}} : sum_v[p][VMEM_W-1:0];
            fire[p]   = next_v[p] >= VMEM_W'(V_THRESH);
        end
    end

    // Membrane write back; fired PEs restart from zero
    always_ff @(posedge clk) begin
        if (!rst_n || clear_run) begin
            for (int r = 0; r < ROWS; r++) begin
                for (int p = 0; p < PE_COUNT; p++) begin
                    vmem[r][p] <= '0;
                end
            end
        end else if (syn_in.valid) begin
            for (int p = 0; p < PE_COUNT; p++) begin
                vmem[syn_in.row][p] <= fire[p] ? '0 : next_v[p];
            end
        end
    end

    // ====================
    // Output beat
    // ====================
    // A beat arriving with clear_run is dropped, the clear wins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            spike_beat <= '0;
        end else begin
            spike_beat.valid    <= syn_in.valid && !clear_run;
            spike_beat.row      <= syn_in.row;
            spike_beat.timestep <= syn_in.timestep;
            spike_beat.spikes   <= fire;     // Only meaningful with valid
        end
    end

endmodule

`default_nettype wire

//--- verilog/snn_pkg.sv
// Shared sizes, LIF constants, beat structs and host read source
// encoding for the SNN spike readout tile
`default_nettype none

package snn_pkg;

    // ====================
    // Array sizes
    // ====================
    localparam int ROWS          = 8;      // Rows per layer
    localparam int ROW_W         = 3;
    localparam int PE_COUNT      = 16;     // Spike vector width
    localparam int PE_W          = 4;
    localparam int MAX_TIMESTEPS = 16;     // Buffer depth in timesteps
    localparam int TS_W          = 4;
    localparam int BUF_DEPTH     = MAX_TIMESTEPS * ROWS;  // 128 words
    localparam int ADDR_W        = 7;      // Host address, timestep * ROWS + row

    // ====================
    // LIF neuron constants
    // ====================
    localparam int CUR_W         = 6;      // Unsigned synaptic current
    localparam int VMEM_W        = 8;      // Unsigned membrane potential
    localparam int V_THRESH      = 40;     // Fire at or above this
    localparam int LEAK_SHIFT    = 3;      // Leak of v/8 per beat

    // Counter widths, both saturate
    localparam int RATE_W        = 8;      // Per-PE spike count, max 255
    localparam int CNT_W         = 8;      // Nonzero beat count

    // ====================
    // Beat types
    // ====================
    typedef struct packed {
        logic                           valid;
        logic [ROW_W-1:0]               row;
        logic [TS_W-1:0]                timestep;
        logic [PE_COUNT-1:0][CUR_W-1:0] current;   // One current per PE
    } syn_beat_t;

    typedef struct packed {
        logic                valid;
        logic [ROW_W-1:0]    row;
        logic [TS_W-1:0]     timestep;
        logic [PE_COUNT-1:0] spikes;               // Bit per PE
    } spike_beat_t;

    // Host read source
    typedef enum logic {
        RD_SPIKES = 1'b0,   // Spike buffer word
        RD_RATES  = 1'b1    // Per-PE rate counter
    } rd_src_e;

endpackage

`default_nettype wire
